// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ifu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/bpu.sv
// Direct-mapped BTB, 2-bit counters, updates visible from the next cycle, targets stored as words
module bpu
#(
   parameter int BTB_P_NUM = 3
)
(
   input                        clk,
   input                        rst_n_i,
   input  ifu_pkg::addr_t       lookup_pc_i,
   input                        upd_valid_i,
   input  ifu_pkg::bpu_upd_t    upd_i,
   output ifu_pkg::bpu_pred_t   pred_o
);
   import ifu_pkg::*;

   localparam int NUM   = 1 << BTB_P_NUM;
   localparam int TAG_W = 30 - BTB_P_NUM;

   logic [NUM-1:0]       valid_q;
   logic [TAG_W-1:0]     tag_q [NUM];
   logic [29:0]          tgt_q [NUM];
   ctr_t                 cnt_q [NUM];

   logic [BTB_P_NUM-1:0] l_idx;
   logic [TAG_W-1:0]     l_tag;
   logic                 l_hit;
   logic [BTB_P_NUM-1:0] u_idx;
   logic [TAG_W-1:0]     u_tag;
   logic                 u_hit;
   logic                 u_en;

   // Index and tag skip the byte offset
   assign l_idx = lookup_pc_i[BTB_P_NUM+1:2];
   assign l_tag = lookup_pc_i[31:BTB_P_NUM+2];
   assign u_idx = upd_i.pc[BTB_P_NUM+1:2];
   assign u_tag = upd_i.pc[31:BTB_P_NUM+2];

   assign l_hit = valid_q[l_idx] && (tag_q[l_idx] == l_tag);
   assign u_hit = valid_q[u_idx] && (tag_q[u_idx] == u_tag);
   assign u_en  = upd_valid_i & upd_i.is_branch;

   // Taken when the counter MSB is set
   assign pred_o.taken  = l_hit & cnt_q[l_idx][1];
   assign pred_o.target = {tgt_q[l_idx], 2'b00};

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         valid_q <= '0;
      else if (u_en)
         valid_q[u_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (u_en)
      begin
         if (!u_hit)
         begin
            // Allocate weakly toward the first outcome
            tag_q[u_idx] <= u_tag;
            tgt_q[u_idx] <= upd_i.target[31:2];
            cnt_q[u_idx] <= upd_i.taken ? 2'd2 : 2'd1;
         end
         else if (upd_i.taken)
         begin
            tgt_q[u_idx] <= upd_i.target[31:2];
            if (cnt_q[u_idx] != 2'd3)
               cnt_q[u_idx] <= cnt_q[u_idx] + 2'd1;
         end
         else if (cnt_q[u_idx] != 2'd0)
         begin
            cnt_q[u_idx] <= cnt_q[u_idx] - 2'd1;
         end
      end
   end

endmodule

// File: design/fetch_ctrl.sv
// Flush target must be word aligned; at most two fetches are in flight and each has a queue slot
module fetch_ctrl
#(
   parameter int             FQ_P_DEPTH = 2,
   parameter ifu_pkg::addr_t RESET_PC   = 32'h0000_0000
)
(
   input                              clk,
   input                              rst_n_i,
   input                              flush_i,
   input  ifu_pkg::addr_t             flush_tgt_i,
   input  ifu_pkg::bpu_pred_t         pred_i,
   input                              req_ready_i,
   input                              resp_done_i,
   input  logic [FQ_P_DEPTH:0]        fq_free_i,
   output ifu_pkg::addr_t             lookup_pc_o,
   output logic                       req_valid_o,
   output ifu_pkg::fetch_req_t        req_o,
   output ifu_pkg::epoch_t            epoch_o
);
   import ifu_pkg::*;

   addr_t      pc_q;
   addr_t      pc_nxt;
   epoch_t     epoch_q;
   logic [1:0] inflight_q;
   logic [1:0] inflight_nxt;
   logic       credit_ok;
   logic       req_fire;

   // Room for one more read, both on the bus and in the queue
   assign credit_ok = (inflight_q < 2'd2) &&
                      ({{FQ_P_DEPTH{1'b0}}, inflight_q} < {1'b0, fq_free_i});

   assign req_valid_o = ~flush_i & credit_ok;
   assign req_fire    = req_valid_o & req_ready_i;

   assign lookup_pc_o = pc_q;
   assign epoch_o     = epoch_q;

   always_comb
   begin
      req_o.pc          = pc_q;
      req_o.pred_taken  = pred_i.taken;
      req_o.pred_target = pred_i.target;
      req_o.epoch       = epoch_q;
   end

   // Next PC select
   always_comb
   begin
      if (flush_i)
         pc_nxt = flush_tgt_i;
      else if (req_fire && pred_i.taken)
         pc_nxt = pred_i.target;
      else if (req_fire)
         pc_nxt = pc_q + 32'd4;
      else
         pc_nxt = pc_q;
   end

   // Requests between acceptance and their R beat
   always_comb
   begin
      inflight_nxt = inflight_q;
      if (req_fire && !resp_done_i)
         inflight_nxt = inflight_q + 2'd1;
      else if (!req_fire && resp_done_i)
         inflight_nxt = inflight_q - 2'd1;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         pc_q       <= RESET_PC;
         epoch_q    <= 1'b0;
         inflight_q <= 2'd0;
      end
      else
      begin
         pc_q       <= pc_nxt;
         inflight_q <= inflight_nxt;
         if (flush_i)
            epoch_q <= ~epoch_q;
      end
   end

   // The memory port never holds more than two reads
   a_inflight_max: assert property (@(posedge clk) disable iff (!rst_n_i)
      inflight_q <= 2'd2)
      else $error("fetch_ctrl: more than two reads in flight");

   // Flush targets and BTB targets keep the PC aligned
   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
      pc_q[1:0] == 2'b00)
      else $error("fetch_ctrl: PC 0x%08h not word aligned", pc_q);

endmodule

// File: design/fetch_queue.sv
// Power-of-two queue toward decode, flush wins over a push in the same cycle
module fetch_queue
#(
   parameter int FQ_P_DEPTH = 2
)
(
   input                              clk,
   input                              rst_n_i,
   input                              flush_i,
   input                              push_valid_i,
   input  ifu_pkg::fetch_entry_t      push_i,
   output logic [FQ_P_DEPTH:0]        free_o,
   output logic                       dec_valid_o,
   input                              dec_ready_i,
   output ifu_pkg::fetch_entry_t      dec_o
);
   import ifu_pkg::*;

   localparam int                    DEPTH   = 1 << FQ_P_DEPTH;
   localparam logic [FQ_P_DEPTH:0]   DEPTH_C = (FQ_P_DEPTH+1)'(DEPTH);

   fetch_entry_t            mem_q [DEPTH];
   logic [FQ_P_DEPTH-1:0]   wr_ptr_q;
   logic [FQ_P_DEPTH-1:0]   rd_ptr_q;
   logic [FQ_P_DEPTH:0]     cnt_q;
   logic                    pop;

   assign dec_valid_o = (cnt_q != '0);
   assign dec_o       = mem_q[rd_ptr_q];
   assign pop         = dec_valid_o & dec_ready_i;
   assign free_o      = DEPTH_C - cnt_q;

   always_ff @(posedge clk)
   begin
      if (push_valid_i)
         mem_q[wr_ptr_q] <= push_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || flush_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (push_valid_i)
            wr_ptr_q <= wr_ptr_q + FQ_P_DEPTH'(1);
         if (pop)
            rd_ptr_q <= rd_ptr_q + FQ_P_DEPTH'(1);
         if (push_valid_i && !pop)
            cnt_q <= cnt_q + (FQ_P_DEPTH+1)'(1);
         else if (!push_valid_i && pop)
            cnt_q <= cnt_q - (FQ_P_DEPTH+1)'(1);
      end
   end

   // Credits in fetch_ctrl reserve a slot for every read
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
      push_valid_i |-> (cnt_q != DEPTH_C))
      else $error("fetch_queue: push into full queue");

endmodule

// File: design/ifu_pkg.sv
// Types for a single-issue fetch unit with 32-bit byte addresses, one aligned word per fetch
package ifu_pkg;

   // Meaningful widths
   typedef logic [31:0] addr_t;
   typedef logic [31:0] insn_t;
   typedef logic        epoch_t;
   typedef logic [1:0]  ctr_t;
   typedef logic [1:0]  axi_resp_t;
   typedef logic [2:0]  axi_prot_t;

   // Unprivileged, secure, instruction access
   localparam axi_prot_t PROT_INSN = 3'b100;
   localparam axi_resp_t RESP_OKAY = 2'b00;

   // Request handed from control to the memory port
   typedef struct packed {
      addr_t  pc;
      logic   pred_taken;
      addr_t  pred_target;
      epoch_t epoch;
   } fetch_req_t;

   // One slot of the queue toward decode
   typedef struct packed {
      addr_t pc;
      insn_t insn;
      logic  pred_taken;
      addr_t pred_target;
      logic  exc;
   } fetch_entry_t;

   // Resolved branch from execute, low two PC bits unused
   typedef struct packed {
      logic  is_branch;
      logic  taken;
      addr_t pc;
      addr_t target;
   } bpu_upd_t;

   // Combinational lookup result
   typedef struct packed {
      logic  taken;
      addr_t target;
   } bpu_pred_t;

endpackage

// File: design/ifu_top.sv
// Fetch unit top, one instruction per cycle to decode, AXI4-Lite read channels only
module ifu_top
#(
   parameter int             BTB_P_NUM  = 3,
   parameter int             FQ_P_DEPTH = 2,
   parameter ifu_pkg::addr_t RESET_PC   = 32'h0000_0000
)
(
   input                              clk,
   input                              rst_n_i,
   input                              flush_i,
   input  ifu_pkg::addr_t             flush_tgt_i,
   // Branch resolution from execute
   input                              upd_valid_i,
   input  ifu_pkg::bpu_upd_t          upd_i,
   // AXI4-Lite read master
   output logic                       arvalid_o,
   input                              arready_i,
   output ifu_pkg::addr_t             araddr_o,
   output ifu_pkg::axi_prot_t         arprot_o,
   input                              rvalid_i,
   output logic                       rready_o,
   input  ifu_pkg::insn_t             rdata_i,
   input  ifu_pkg::axi_resp_t         rresp_i,
   // Decode side
   output logic                       dec_valid_o,
   input                              dec_ready_i,
   output ifu_pkg::fetch_entry_t      dec_o
);
   import ifu_pkg::*;

   addr_t               lookup_pc;
   bpu_pred_t           pred;
   logic                req_valid;
   logic                req_ready;
   fetch_req_t          req;
   epoch_t              epoch;
   logic                resp_done;
   logic                push_valid;
   fetch_entry_t        push;
   logic [FQ_P_DEPTH:0] fq_free;

   fetch_ctrl
      #(.FQ_P_DEPTH (FQ_P_DEPTH),
        .RESET_PC   (RESET_PC))
   u_fetch_ctrl
      (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .flush_i     (flush_i),
         .flush_tgt_i (flush_tgt_i),
         .pred_i      (pred),
         .req_ready_i (req_ready),
         .resp_done_i (resp_done),
         .fq_free_i   (fq_free),
         .lookup_pc_o (lookup_pc),
         .req_valid_o (req_valid),
         .req_o       (req),
         .epoch_o     (epoch)
      );

   bpu
      #(.BTB_P_NUM (BTB_P_NUM))
   u_bpu
      (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .lookup_pc_i (lookup_pc),
         .upd_valid_i (upd_valid_i),
         .upd_i       (upd_i),
         .pred_o      (pred)
      );

   imem_port u_imem_port
      (
         .clk          (clk),
         .rst_n_i      (rst_n_i),
         .req_valid_i  (req_valid),
         .req_i        (req),
         .epoch_i      (epoch),
         .req_ready_o  (req_ready),
         .arvalid_o    (arvalid_o),
         .arready_i    (arready_i),
         .araddr_o     (araddr_o),
         .arprot_o     (arprot_o),
         .rvalid_i     (rvalid_i),
         .rready_o     (rready_o),
         .rdata_i      (rdata_i),
         .rresp_i      (rresp_i),
         .push_valid_o (push_valid),
         .push_o       (push),
         .resp_done_o  (resp_done)
      );

   // Flushed together with the epoch toggle
   fetch_queue
      #(.FQ_P_DEPTH (FQ_P_DEPTH))
   u_fetch_queue
      (
         .clk          (clk),
         .rst_n_i      (rst_n_i),
         .flush_i      (flush_i),
         .push_valid_i (push_valid),
         .push_i       (push),
         .free_o       (fq_free),
         .dec_valid_o  (dec_valid_o),
         .dec_ready_i  (dec_ready_i),
         .dec_o        (dec_o)
      );

endmodule

// File: design/imem_port.sv
// AXI4-Lite single-word reads, at most two outstanding, in-order responses assumed
module imem_port
(
   input                             clk,
   input                             rst_n_i,
   input                             req_valid_i,
   input  ifu_pkg::fetch_req_t       req_i,
   input  ifu_pkg::epoch_t           epoch_i,
   output logic                      req_ready_o,
   // AR channel
   output logic                      arvalid_o,
   input                             arready_i,
   output ifu_pkg::addr_t            araddr_o,
   output ifu_pkg::axi_prot_t        arprot_o,
   // R channel
   input                             rvalid_i,
   output logic                      rready_o,
   input  ifu_pkg::insn_t            rdata_i,
   input  ifu_pkg::axi_resp_t        rresp_i,
   // Toward queue and control
   output logic                      push_valid_o,
   output ifu_pkg::fetch_entry_t     push_o,
   output logic                      resp_done_o
);
   import ifu_pkg::*;

   fetch_req_t fifo_q [2];
   fetch_req_t head;
   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] cnt_q;
   logic       ar_pend_q;
   addr_t      araddr_q;
   logic       req_fire;
   logic       r_fire;

   // New request only once the previous address has gone out
   assign req_ready_o = (~ar_pend_q | arready_i) & (cnt_q != 2'd2);
   assign req_fire    = req_valid_i & req_ready_o;

   assign arvalid_o = ar_pend_q;
   assign araddr_o  = araddr_q;
   assign arprot_o  = PROT_INSN;

   assign rready_o = (cnt_q != 2'd0);
   assign r_fire   = rvalid_i & rready_o;
   assign head     = fifo_q[rd_ptr_q];

   // Responses from before the last flush are dropped here
   assign push_valid_o       = r_fire && (head.epoch == epoch_i);
   assign push_o.pc          = head.pc;
   assign push_o.insn        = rdata_i;
   assign push_o.pred_taken  = head.pred_taken;
   assign push_o.pred_target = head.pred_target;
   assign push_o.exc         = (rresp_i != RESP_OKAY);
   assign resp_done_o        = r_fire;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         ar_pend_q <= 1'b0;
      else if (req_fire)
         ar_pend_q <= 1'b1;
      else if (arready_i)
         ar_pend_q <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (req_fire)
      begin
         araddr_q         <= req_i.pc;
         fifo_q[wr_ptr_q] <= req_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         cnt_q    <= 2'd0;
      end
      else
      begin
         if (req_fire)
            wr_ptr_q <= ~wr_ptr_q;
         if (r_fire)
            rd_ptr_q <= ~rd_ptr_q;
         if (req_fire && !r_fire)
            cnt_q <= cnt_q + 2'd1;
         else if (!req_fire && r_fire)
            cnt_q <= cnt_q - 2'd1;
      end
   end

   // Slave must not answer a read that was never issued
   a_r_without_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      rvalid_i |-> (cnt_q != 2'd0))
      else $error("imem_port: R beat with no read outstanding");

   a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
      else $error("imem_port: AR changed while stalled");

endmodule

// File: sources.f
design/ifu_pkg.sv
design/fetch_ctrl.sv
design/bpu.sv
design/imem_port.sv
design/fetch_queue.sv
design/ifu_top.sv
test/axi_lite_mem.sv
test/ifu_tb.sv

// File: test/axi_lite_mem.sv
// Read-only AXI4-Lite slave for simulation; in-order responses, fixed seed, error over one range
module axi_lite_mem
#(
   parameter logic [31:0] SEED     = 32'hc36d_ef75,
   parameter logic [31:0] INSN_XOR = 32'hc0de_0000,
   parameter logic [31:0] ERR_LO   = 32'h0000_0f00,
   parameter logic [31:0] ERR_HI   = 32'h0000_0fff
)
(
   input               clk,
   input               rst_n_i,
   input               arvalid_i,
   output logic        arready_o,
   input        [31:0] araddr_i,
   output logic        rvalid_o,
   input               rready_i,
   output logic [31:0] rdata_o,
   output logic [1:0]  rresp_o
);

   logic [31:0] pend_q [$];
   logic [31:0] ar_addr;
   logic [31:0] r_addr;
   logic        ar_hs;
   logic        r_hs;
   logic        in_rst;
   integer      seed;
   int          r_wait;

   initial
   begin
      seed      = SEED;
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rdata_o   = '0;
      rresp_o   = 2'b00;
      r_wait    = 0;
   end

   always @(posedge clk)
   begin
      // Handshakes as seen at the edge
      in_rst  = !rst_n_i;
      ar_hs   = arvalid_i && arready_o;
      r_hs    = rvalid_o && rready_i;
      ar_addr = araddr_i;
      #1;
      if (in_rst)
      begin
         pend_q.delete();
         arready_o = 1'b0;
         rvalid_o  = 1'b0;
      end
      else
      begin
         if (ar_hs)
            pend_q.push_back(ar_addr);
         if (r_hs)
            rvalid_o = 1'b0;
         // Ready about three cycles in four
         arready_o = ($unsigned($random(seed)) % 4) != 0;
         if (!rvalid_o && pend_q.size() > 0)
         begin
            if (r_wait > 0)
               r_wait = r_wait - 1;
            else
            begin
               r_addr   = pend_q.pop_front();
               rvalid_o = 1'b1;
               rdata_o  = r_addr ^ INSN_XOR;
               rresp_o  = (r_addr >= ERR_LO && r_addr <= ERR_HI) ? 2'b10 : 2'b00;
               r_wait   = int'($unsigned($random(seed)) % 4);
            end
         end
      end
   end

endmodule

// File: test/ifu_tb.sv
// Fixed seed; BTB trained only while decode is held and then flushed, flushes spaced so reads drain
module ifu_tb;
   import ifu_pkg::*;

   localparam int          BTB_P_NUM  = 3;
   localparam int          FQ_P_DEPTH = 2;
   localparam int          BTB_N      = 1 << BTB_P_NUM;
   localparam addr_t       RESET_PC   = 32'h0000_0000;
   localparam logic [31:0] INSN_XOR   = 32'hc0de_0000;
   localparam addr_t       ERR_LO     = 32'h0000_0f00;
   localparam addr_t       ERR_HI     = 32'h0000_0fff;
   localparam addr_t       BR_PC      = 32'h0000_0100;
   localparam addr_t       BR_TGT     = 32'h0000_0200;
   // Instruction access, secure and unprivileged
   localparam logic [2:0]  PROT_FETCH = 3'b100;
   localparam int          RDY_HOLD   = 0;
   localparam int          RDY_RAND   = 1;
   localparam int          RDY_RARE   = 2;

   logic         clk;
   logic         rst_n;
   logic         flush;
   addr_t        flush_tgt;
   logic         upd_valid;
   bpu_upd_t     upd;
   logic         arvalid;
   logic         arready;
   addr_t        araddr;
   axi_prot_t    arprot;
   logic         rvalid;
   logic         rready;
   insn_t        rdata;
   axi_resp_t    rresp;
   logic         dec_valid;
   logic         dec_ready;
   fetch_entry_t dec;

   integer       seed = 32'hc36d_ef75;
   int           ready_mode;
   int           n_chk;
   int           n_taken;
   int           n_exc;
   int           chk_err;
   int           run_err;
   int           tmo_cnt;
   addr_t        exp_pc;

   // Reference copy of the BTB state
   logic         m_valid [BTB_N];
   addr_t        m_pc    [BTB_N];
   addr_t        m_tgt   [BTB_N];
   logic [1:0]   m_cnt   [BTB_N];

   ifu_top
      #(.BTB_P_NUM  (BTB_P_NUM),
        .FQ_P_DEPTH (FQ_P_DEPTH),
        .RESET_PC   (RESET_PC))
   dut_i
      (
         .clk         (clk),
         .rst_n_i     (rst_n),
         .flush_i     (flush),
         .flush_tgt_i (flush_tgt),
         .upd_valid_i (upd_valid),
         .upd_i       (upd),
         .arvalid_o   (arvalid),
         .arready_i   (arready),
         .araddr_o    (araddr),
         .arprot_o    (arprot),
         .rvalid_i    (rvalid),
         .rready_o    (rready),
         .rdata_i     (rdata),
         .rresp_i     (rresp),
         .dec_valid_o (dec_valid),
         .dec_ready_i (dec_ready),
         .dec_o       (dec)
      );

   axi_lite_mem
      #(.SEED     (32'hc36d_ef75),
        .INSN_XOR (INSN_XOR),
        .ERR_LO   (ERR_LO),
        .ERR_HI   (ERR_HI))
   u_mem
      (
         .clk       (clk),
         .rst_n_i   (rst_n),
         .arvalid_i (arvalid),
         .arready_o (arready),
         .araddr_i  (araddr),
         .rvalid_o  (rvalid),
         .rready_i  (rready),
         .rdata_o   (rdata),
         .rresp_o   (rresp)
      );

   always #2 clk = ~clk;

   function automatic int btb_idx(input addr_t pc);
      return int'(pc[BTB_P_NUM+1:2]);
   endfunction

   function automatic logic model_taken(input addr_t pc);
      int idx;
      idx = btb_idx(pc);
      return m_valid[idx] && (m_pc[idx][31:2] == pc[31:2]) && (m_cnt[idx] >= 2'd2);
   endfunction

   function automatic addr_t model_target(input addr_t pc);
      return {m_tgt[btb_idx(pc)][31:2], 2'b00};
   endfunction

   function automatic logic in_err_window(input addr_t pc);
      return (pc >= ERR_LO) && (pc <= ERR_HI);
   endfunction

   // Every entry handed to decode is compared with the model
   always @(posedge clk)
   begin
      if (rst_n && dec_valid && dec_ready)
      begin
         n_chk++;
         assert (dec.pc == exp_pc)
         else
         begin
            $display("** Error: dec_o.pc = 0x%08h, expected 0x%08h", dec.pc, exp_pc);
            chk_err++;
         end
         assert (dec.insn == (dec.pc ^ INSN_XOR))
         else
         begin
            $display("** Error: dec_o.insn = 0x%08h, expected 0x%08h",
                     dec.insn, dec.pc ^ INSN_XOR);
            chk_err++;
         end
         assert (dec.exc == in_err_window(dec.pc))
         else
         begin
            $display("** Error: dec_o.exc = 0x%0h, expected 0x%0h at pc 0x%08h",
                     dec.exc, in_err_window(dec.pc), dec.pc);
            chk_err++;
         end
         assert (dec.pred_taken == model_taken(dec.pc))
         else
         begin
            $display("** Error: dec_o.pred_taken = 0x%0h, expected 0x%0h at pc 0x%08h",
                     dec.pred_taken, model_taken(dec.pc), dec.pc);
            chk_err++;
         end
         if (model_taken(dec.pc))
         begin
            assert (dec.pred_target == model_target(dec.pc))
            else
            begin
               $display("** Error: dec_o.pred_target = 0x%08h, expected 0x%08h",
                        dec.pred_target, model_target(dec.pc));
               chk_err++;
            end
            n_taken++;
            exp_pc = model_target(dec.pc);
         end
         else
            exp_pc = dec.pc + 32'd4;
         if (dec.exc)
            n_exc++;
      end
      // Entries popped at the flush edge still belong to the old path
      if (rst_n && flush)
         exp_pc = flush_tgt;
   end

   // Every read address goes out marked as an instruction fetch
   always @(posedge clk)
   begin
      if (rst_n && arvalid)
      begin
         assert (arprot == PROT_FETCH)
         else
         begin
            $display("** Error: arprot_o = 0x%0h, expected 0x%0h", arprot, PROT_FETCH);
            chk_err++;
         end
      end
   end

   // One clock, then decode ready for the new cycle
   task automatic step();
      @(posedge clk);
      #1;
      case (ready_mode)
         RDY_HOLD: dec_ready = 1'b0;
         RDY_RARE: dec_ready = ($unsigned($random(seed)) % 8) == 0;
         default:  dec_ready = ($unsigned($random(seed)) % 2) == 1;
      endcase
   endtask

   task automatic wait_entries(input int n, input int limit);
      int target;
      int cyc;
      target = n_chk + n;
      cyc    = 0;
      while (n_chk < target && cyc < limit)
      begin
         step();
         cyc++;
      end
      if (n_chk < target)
      begin
         $display("Timeout: only %0d of %0d decode entries arrived within %0d cycles",
                  n - (target - n_chk), n, limit);
         tmo_cnt++;
      end
   endtask

   task automatic train(input addr_t pc, input addr_t tgt, input logic taken);
      int   idx;
      logic hit;
      idx = btb_idx(pc);
      hit = m_valid[idx] && (m_pc[idx][31:2] == pc[31:2]);
      upd_valid       = 1'b1;
      upd.is_branch   = 1'b1;
      upd.taken       = taken;
      upd.pc          = pc;
      upd.target      = tgt;
      if (!hit)
      begin
         m_valid[idx] = 1'b1;
         m_pc[idx]    = pc;
         m_tgt[idx]   = tgt;
         m_cnt[idx]   = taken ? 2'd2 : 2'd1;
      end
      else if (taken)
      begin
         m_tgt[idx] = tgt;
         if (m_cnt[idx] != 2'd3)
            m_cnt[idx] = m_cnt[idx] + 2'd1;
      end
      else if (m_cnt[idx] != 2'd0)
         m_cnt[idx] = m_cnt[idx] - 2'd1;
      step();
      upd_valid = 1'b0;
   endtask

   task automatic flush_to(input addr_t tgt);
      flush     = 1'b1;
      flush_tgt = tgt;
      step();
      flush     = 1'b0;
   endtask

   task automatic run_test();
      int i;
      for (i = 0; i < 4; i++)
         step();
      rst_n = 1'b1;
      assert (!arvalid && !rready && !dec_valid)
      else
      begin
         $display("AXI and decode outputs were not idle after reset");
         run_err++;
      end

      // Straight-line fetch from the reset PC
      ready_mode = RDY_RAND;
      wait_entries(24, 400);
      if (tmo_cnt != 0)
         return;

      // Forward branch trained taken twice, neighbour allocated not taken
      ready_mode = RDY_HOLD;
      step();
      train(BR_PC, BR_TGT, 1'b1);
      train(BR_PC, BR_TGT, 1'b1);
      train(32'h0000_0108, 32'h0000_0300, 1'b0);
      flush_to(32'h0000_00f0);
      ready_mode = RDY_RAND;
      wait_entries(32, 600);
      if (tmo_cnt != 0)
         return;

      // Two not-taken outcomes drop the prediction
      ready_mode = RDY_HOLD;
      step();
      train(BR_PC, BR_TGT, 1'b0);
      train(BR_PC, BR_TGT, 1'b0);
      flush_to(32'h0000_00f0);
      ready_mode = RDY_RAND;
      wait_entries(24, 600);
      if (tmo_cnt != 0)
         return;

      // Flushes while reads are still outstanding
      for (i = 0; i < 4; i++)
      begin
         wait_entries(6, 400);
         if (tmo_cnt != 0)
            return;
         flush_to(32'h0000_0400 + 32'(i) * 32'h40);
      end
      wait_entries(8, 400);
      if (tmo_cnt != 0)
         return;

      // Long decode stalls through the error window and out of it
      ready_mode = RDY_RARE;
      flush_to(32'h0000_0ee0);
      wait_entries(48, 3000);
      if (tmo_cnt != 0)
         return;
      flush_to(32'h0000_0fe0);
      wait_entries(16, 1500);
   endtask

   initial
   begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      flush      = 1'b0;
      flush_tgt  = '0;
      upd_valid  = 1'b0;
      upd        = '0;
      dec_ready  = 1'b0;
      ready_mode = RDY_HOLD;
      exp_pc     = RESET_PC;
      n_chk      = 0;
      n_taken    = 0;
      n_exc      = 0;
      chk_err    = 0;
      run_err    = 0;
      tmo_cnt    = 0;
      for (int k = 0; k < BTB_N; k++)
      begin
         m_valid[k] = 1'b0;
         m_pc[k]    = '0;
         m_tgt[k]   = '0;
         m_cnt[k]   = 2'd0;
      end

      run_test();

      assert (n_taken > 0)
      else
      begin
         $display("No entry with a taken prediction reached decode");
         run_err++;
      end
      assert (n_exc > 0)
      else
      begin
         $display("No entry from the error window reached decode");
         run_err++;
      end

      $display("Entries checked %0d, check errors %0d, other errors %0d, timeouts %0d",
               n_chk, chk_err, run_err, tmo_cnt);
      if (chk_err == 0 && run_err == 0 && tmo_cnt == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule
